// ==== design/vid_params.svh ====
`ifndef VID_PARAMS_SVH
`define VID_PARAMS_SVH

// Horizontal geometry in pixels
`define VID_HTOTAL  384
`define VID_HVIS    256

// Vertical geometry in lines
`define VID_VTOTAL  264
`define VID_VVIS    224

// Number of hardware objects
`define VID_OBJS    8

// Mixer output latency, in pixel enables
`define VID_MIX_DLY 1

`endif

// ==== design/vid_pkg.sv ====
`default_nettype none

package vid_pkg;

    // Beam position
    typedef logic [8:0]  hpos_t;
    typedef logic [8:0]  vpos_t;

    // Pixel nibble or palette index
    typedef logic [3:0]  nib_t;

    // CPU data byte
    typedef logic [7:0]  byte_t;

    // Tile VRAM address, 32 rows by 64 columns
    typedef logic [10:0] vaddr_t;

    // Layer bit on top of a 4-bit index
    typedef logic [4:0]  color_t;

endpackage

`default_nettype wire

// ==== design/video_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vid_params.svh"

module video_timing (
    input  wire              clk,
    input  wire              rst,
    output logic             pxl_cen,
    output vid_pkg::hpos_t   hdump,
    output vid_pkg::vpos_t   vdump,
    output logic             LHBL,
    output logic             LVBL
);

    vid_pkg::hpos_t hnext;
    vid_pkg::vpos_t vnext;

    // Next beam position, wraps at line and frame ends
    always_comb begin
        hnext = hdump + 9'd1;
        vnext = vdump;
        if (hdump == 9'(`VID_HTOTAL - 1)) begin
            hnext = '0;
            vnext = vdump + 9'd1;
            if (vdump == 9'(`VID_VTOTAL - 1)) begin
                vnext = '0;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pxl_cen <= 1'b0;
            hdump   <= '0;
            vdump   <= '0;
            LHBL    <= 1'b0;
            LVBL    <= 1'b0;
        end else begin
            // Half rate pixel clock
            pxl_cen <= ~pxl_cen;
            if (pxl_cen) begin
                hdump <= hnext;
                vdump <= vnext;
                // Decoded from the next count so blanking lines up with hdump
                LHBL  <= hnext < 9'(`VID_HVIS);
                LVBL  <= vnext < 9'(`VID_VVIS);
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/tile_scroll.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vid_params.svh"

module tile_scroll (
    input  wire              clk,
    input  wire              rst,
    input  wire              pxl_cen,
    input  wire              LHBL,
    input  vid_pkg::hpos_t   hdump,
    input  vid_pkg::vpos_t   vdump,
    input  wire [11:0]       cpu_addr,
    input  vid_pkg::byte_t   cpu_dout,
    input  wire              cpu_rnw,
    input  wire              vram_cs,
    output vid_pkg::byte_t   vram_dout,
    input  vid_pkg::byte_t   scr_din,
    input  wire              scr_we,
    output logic [12:0]      rom_addr,
    input  wire [31:0]       rom_data,
    input  wire [9:0]        prog_addr,
    input  vid_pkg::nib_t    prog_data,
    input  wire              prog_we,
    input  wire              prog_sel,
    output vid_pkg::nib_t    tile_pxl
);

    // 8 pixel offset of the tilemap plus 7 enables of fetch and palette delay
    localparam logic [8:0] LOOKAHEAD = 9'd15;

    // Code and attribute planes, palette PROM
    vid_pkg::byte_t  vram_lo [0:2047];
    vid_pkg::byte_t  vram_hi [0:2047];
    vid_pkg::nib_t   pal     [0:255];

    vid_pkg::byte_t  hpos;
    vid_pkg::hpos_t  hvirt;
    vid_pkg::hpos_t  heff;
    vid_pkg::vpos_t  vrow;
    vid_pkg::vaddr_t cpu_a;
    vid_pkg::vaddr_t rd_addr;
    vid_pkg::byte_t  code;
    vid_pkg::byte_t  attr;
    logic [2:0]      tile_row;
    logic [31:0]     rom_ord;
    logic [31:0]     pxl_data;
    logic            cur_hf;
    vid_pkg::nib_t   cur_pal;
    logic [7:0]      pal_addr;

    assign cpu_a = cpu_addr[10:0];

    // Blanking folds hdump back by a line so fetch runs into column 0
    always_comb begin
        hvirt = LHBL ? hdump : hdump + 9'(512 - `VID_HTOTAL);
        heff  = hvirt + {1'b0, hpos[7:1], 1'b0} + LOOKAHEAD;
        // Fetches during blanking belong to the next line
        vrow  = LHBL ? vdump : vdump + 9'd1;
    end

    // Planar ROM word into eight left to right nibbles
    always_comb begin
        int k;
        int j;
        int b;
        rom_ord = '0;
        for (k = 0; k < 8; k++) begin
            j = k % 4;
            b = (k < 4) ? 16 : 0;
            rom_ord[31 - 4*k -: 4] = {rom_data[b + 11 - j], rom_data[b + 15 - j],
                                      rom_data[b + 3 - j],  rom_data[b + 7 - j]};
        end
    end

    // CPU port, A11 picks the attribute plane
    always_ff @(posedge clk) begin
        if (vram_cs) begin
            if (!cpu_rnw && !cpu_addr[11]) begin
                vram_lo[cpu_a] <= cpu_dout;
            end
            if (!cpu_rnw && cpu_addr[11]) begin
                vram_hi[cpu_a] <= cpu_dout;
            end
            vram_dout <= cpu_addr[11] ? vram_hi[cpu_a] : vram_lo[cpu_a];
        end
    end

    // Video port, read every clk
    always_ff @(posedge clk) begin
        code <= vram_lo[rd_addr];
        attr <= vram_hi[rd_addr];
    end

    // Scroll register and fetch addressing
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hpos     <= '0;
            rd_addr  <= '0;
            tile_row <= '0;
            rom_addr <= '0;
        end else begin
            if (scr_we) begin
                hpos <= scr_din;
            end
            if (pxl_cen && heff[2:0] == 3'd0) begin
                rd_addr  <= {vrow[7:3], heff[8:3]};
                tile_row <= vrow[2:0];
            end
            // VRAM word settled one enable later
            if (pxl_cen && heff[2:0] == 3'd1) begin
                rom_addr <= {attr[7:6], code, tile_row};
            end
        end
    end

    // Pixel shifter, loaded four enables after the ROM address
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            if (heff[2:0] == 3'd5) begin
                pxl_data <= rom_ord;
                cur_hf   <= attr[4];
                cur_pal  <= attr[3:0];
            end else begin
                pxl_data <= cur_hf ? pxl_data >> 4 : pxl_data << 4;
            end
        end
    end

    assign pal_addr = {cur_pal, cur_hf ? pxl_data[3:0] : pxl_data[31:28]};

    // Palette PROM, registered lookup
    always_ff @(posedge clk) begin
        if (prog_we && !prog_sel) begin
            pal[prog_addr[7:0]] <= prog_data;
        end
        if (pxl_cen) begin
            tile_pxl <= pal[pal_addr];
        end
    end

endmodule

`default_nettype wire

// ==== design/sprite_layer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vid_params.svh"

module sprite_layer (
    input  wire              clk,
    input  wire              rst,
    input  wire              pxl_cen,
    input  vid_pkg::hpos_t   hdump,
    input  vid_pkg::vpos_t   vdump,
    input  wire [11:0]       cpu_addr,
    input  vid_pkg::byte_t   cpu_dout,
    input  wire              cpu_rnw,
    input  wire              obj_cs,
    output vid_pkg::byte_t   obj_dout,
    input  wire [9:0]        prog_addr,
    input  vid_pkg::nib_t    prog_data,
    input  wire              prog_we,
    input  wire              prog_sel,
    output vid_pkg::nib_t    obj_pxl,
    output logic             obj_behind
);

    // Four bytes per object: x, y, code, attr
    vid_pkg::byte_t  obj_ram [0:4*`VID_OBJS-1];
    // 16 patterns of 8x8 nibbles
    vid_pkg::nib_t   pat     [0:1023];

    vid_pkg::hpos_t  h2;
    vid_pkg::vpos_t  v2;
    logic            hit;
    logic            hit_behind;
    logic [9:0]      hit_addr;
    logic            s1_hit;
    logic            s1_behind;
    logic [9:0]      s1_addr;

    // Two pixels ahead, wrapping into the next line
    always_comb begin
        h2 = hdump + 9'd2;
        v2 = vdump;
        if (hdump >= 9'(`VID_HTOTAL - 2)) begin
            h2 = hdump + 9'(2 - `VID_HTOTAL);
            v2 = vdump + 9'd1;
        end
    end

    // Parallel hit search, walked downward so object 0 has the last word
    always_comb begin
        int i;
        logic [8:0] dx;
        logic [8:0] dy;
        hit        = 1'b0;
        hit_behind = 1'b0;
        hit_addr   = '0;
        for (i = `VID_OBJS - 1; i >= 0; i--) begin
            dx = h2 - {1'b0, obj_ram[4*i]};
            dy = v2 - {1'b0, obj_ram[4*i + 1]};
            if (dx[8:3] == 6'd0 && dy[8:3] == 6'd0) begin
                hit        = 1'b1;
                hit_behind = obj_ram[4*i + 3][7];
                hit_addr   = {obj_ram[4*i + 2][3:0], dy[2:0], dx[2:0]};
            end
        end
    end

    // Attribute table, CPU side
    always_ff @(posedge clk) begin
        if (obj_cs) begin
            if (!cpu_rnw) begin
                obj_ram[cpu_addr[4:0]] <= cpu_dout;
            end
            obj_dout <= obj_ram[cpu_addr[4:0]];
        end
    end

    // Pattern PROM load
    always_ff @(posedge clk) begin
        if (prog_we && prog_sel) begin
            pat[prog_addr] <= prog_data;
        end
    end

    // Search result, then pattern read
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_hit     <= 1'b0;
            s1_behind  <= 1'b0;
            s1_addr    <= '0;
            obj_pxl    <= '0;
            obj_behind <= 1'b0;
        end else if (pxl_cen) begin
            s1_hit     <= hit;
            s1_behind  <= hit & hit_behind;
            s1_addr    <= hit_addr;
            // No cover gives a transparent pixel
            obj_pxl    <= s1_hit ? pat[s1_addr] : 4'd0;
            obj_behind <= s1_behind;
        end
    end

endmodule

`default_nettype wire

// ==== design/layer_mixer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vid_params.svh"

module layer_mixer (
    input  wire              clk,
    input  wire              rst,
    input  wire              pxl_cen,
    input  wire              LHBL,
    input  wire              LVBL,
    input  vid_pkg::nib_t    tile_pxl,
    input  vid_pkg::nib_t    obj_pxl,
    input  wire              obj_behind,
    output vid_pkg::color_t  pxl
);

    logic obj_wins;

    // Opaque object over the tiles, or behind and the tile is empty
    assign obj_wins = (obj_pxl != 4'd0) && (!obj_behind || tile_pxl == 4'd0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pxl <= '0;
        end else if (pxl_cen) begin
            if (!LHBL || !LVBL) begin
                pxl <= '0;
            end else if (obj_wins) begin
                pxl <= {1'b1, obj_pxl};
            end else begin
                pxl <= {1'b0, tile_pxl};
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/video_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vid_params.svh"

module video_top (
    input  wire              clk,
    input  wire              rst,
    input  wire [11:0]       cpu_addr,
    input  vid_pkg::byte_t   cpu_dout,
    input  wire              cpu_rnw,
    input  wire              vram_cs,
    input  wire              obj_cs,
    output vid_pkg::byte_t   vram_dout,
    output vid_pkg::byte_t   obj_dout,
    input  vid_pkg::byte_t   scr_din,
    input  wire              scr_we,
    input  wire [9:0]        prog_addr,
    input  vid_pkg::nib_t    prog_data,
    input  wire              prog_we,
    input  wire              prog_sel,
    output logic [12:0]      rom_addr,
    input  wire [31:0]       rom_data,
    output vid_pkg::color_t  pxl,
    output vid_pkg::hpos_t   hdump,
    output vid_pkg::vpos_t   vdump,
    output logic             LHBL,
    output logic             LVBL
);

    logic           pxl_cen;
    vid_pkg::nib_t  tile_pxl;
    vid_pkg::nib_t  obj_pxl;
    logic           obj_behind;

    video_timing u_timing (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .hdump   (hdump),
        .vdump   (vdump),
        .LHBL    (LHBL),
        .LVBL    (LVBL)
    );

    // Background layer
    tile_scroll u_tiles (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .LHBL      (LHBL),
        .hdump     (hdump),
        .vdump     (vdump),
        .cpu_addr  (cpu_addr),
        .cpu_dout  (cpu_dout),
        .cpu_rnw   (cpu_rnw),
        .vram_cs   (vram_cs),
        .vram_dout (vram_dout),
        .scr_din   (scr_din),
        .scr_we    (scr_we),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .prog_we   (prog_we),
        .prog_sel  (prog_sel),
        .tile_pxl  (tile_pxl)
    );

    // Object layer, same pixel alignment as the tiles
    sprite_layer u_objs (
        .clk        (clk),
        .rst        (rst),
        .pxl_cen    (pxl_cen),
        .hdump      (hdump),
        .vdump      (vdump),
        .cpu_addr   (cpu_addr),
        .cpu_dout   (cpu_dout),
        .cpu_rnw    (cpu_rnw),
        .obj_cs     (obj_cs),
        .obj_dout   (obj_dout),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .prog_we    (prog_we),
        .prog_sel   (prog_sel),
        .obj_pxl    (obj_pxl),
        .obj_behind (obj_behind)
    );

    layer_mixer u_mixer (
        .clk        (clk),
        .rst        (rst),
        .pxl_cen    (pxl_cen),
        .LHBL       (LHBL),
        .LVBL       (LVBL),
        .tile_pxl   (tile_pxl),
        .obj_pxl    (obj_pxl),
        .obj_behind (obj_behind),
        .pxl        (pxl)
    );

endmodule

`default_nettype wire

// ==== tb/video_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vid_params.svh"

module video_tb;

    // Two frames of pixels
    localparam int WAIT_LIMIT = 2 * `VID_HTOTAL * `VID_VTOTAL;
    localparam int CAP_LINE   = 40;

    logic             clk;
    logic             rst;
    logic [11:0]      cpu_addr;
    vid_pkg::byte_t   cpu_dout;
    logic             cpu_rnw;
    logic             vram_cs;
    logic             obj_cs;
    vid_pkg::byte_t   vram_dout;
    vid_pkg::byte_t   obj_dout;
    vid_pkg::byte_t   scr_din;
    logic             scr_we;
    logic [9:0]       prog_addr;
    vid_pkg::nib_t    prog_data;
    logic             prog_we;
    logic             prog_sel;
    logic [12:0]      rom_addr;
    logic [31:0]      rom_data;
    vid_pkg::color_t  pxl;
    vid_pkg::hpos_t   hdump;
    vid_pkg::vpos_t   vdump;
    logic             LHBL;
    logic             LVBL;

    // What the CPU side has written so far
    vid_pkg::byte_t   code_sh [0:2047];
    vid_pkg::byte_t   attr_sh [0:2047];
    vid_pkg::byte_t   obj_sh  [0:31];
    vid_pkg::byte_t   scroll_sh;
    // One captured line, and the unscrolled reference copy
    vid_pkg::color_t  cap     [0:255];
    vid_pkg::color_t  base    [0:255];
    int               checks;
    int               errors;

    video_top uut (.*);

    // ROM model, code LSB sits just above the three row bits
    assign rom_data = rom_addr[3] ? 32'hFFFF_FFFF : 32'h0000_0000;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        errors++;
        $display("Fail %s: got %h expected %h", name, got, exp);
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout while waiting for %s", what);
        $display(">>> FAIL");
        $finish;
    endtask

    // Stops at the last clk of a pixel, counters stable
    task automatic wait_pixel();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!uut.pxl_cen && n < 4);
        if (!uut.pxl_cen) timeout_fail("the pixel enable");
    endtask

    task automatic wait_beam(input int h, input int v);
        int n;
        n = 0;
        while ((hdump != 9'(h) || vdump != 9'(v)) && n < WAIT_LIMIT) begin
            wait_pixel();
            n++;
        end
        if (hdump != 9'(h) || vdump != 9'(v)) timeout_fail("a beam position");
    endtask

    task automatic wait_vblank();
        int n;
        n = 0;
        do begin
            wait_pixel();
            n++;
        end while (LVBL && n < WAIT_LIMIT);
        if (LVBL) timeout_fail("vertical blanking");
    endtask

    task automatic cpu_write(input logic to_obj, input logic [11:0] addr,
                             input vid_pkg::byte_t data);
        @(posedge clk);
        #2;
        cpu_addr = addr;
        cpu_dout = data;
        cpu_rnw  = 1'b0;
        vram_cs  = !to_obj;
        obj_cs   = to_obj;
        @(posedge clk);
        #2;
        vram_cs  = 1'b0;
        obj_cs   = 1'b0;
        cpu_rnw  = 1'b1;
        if (to_obj) obj_sh[addr[4:0]] = data;
        else if (addr[11]) attr_sh[addr[10:0]] = data;
        else code_sh[addr[10:0]] = data;
    endtask

    task automatic cpu_read(input logic to_obj, input logic [11:0] addr,
                            output vid_pkg::byte_t data);
        @(posedge clk);
        #2;
        cpu_addr = addr;
        cpu_rnw  = 1'b1;
        vram_cs  = !to_obj;
        obj_cs   = to_obj;
        @(posedge clk);
        #2;
        vram_cs  = 1'b0;
        obj_cs   = 1'b0;
        data     = to_obj ? obj_dout : vram_dout;
    endtask

    task automatic prog_load(input logic sel, input logic [9:0] addr,
                             input vid_pkg::nib_t data);
        @(posedge clk);
        #2;
        prog_sel  = sel;
        prog_addr = addr;
        prog_data = data;
        prog_we   = 1'b1;
        @(posedge clk);
        #2;
        prog_we   = 1'b0;
    endtask

    task automatic set_scroll(input vid_pkg::byte_t val);
        @(posedge clk);
        #2;
        scr_din = val;
        scr_we  = 1'b1;
        @(posedge clk);
        #2;
        scr_we  = 1'b0;
        scroll_sh = val;
    endtask

    task automatic write_obj(input int i, input vid_pkg::byte_t x, input vid_pkg::byte_t y,
                             input vid_pkg::byte_t code, input vid_pkg::byte_t attr);
        cpu_write(1'b1, 12'(4 * i), x);
        cpu_write(1'b1, 12'(4 * i + 1), y);
        cpu_write(1'b1, 12'(4 * i + 2), code);
        cpu_write(1'b1, 12'(4 * i + 3), attr);
    endtask

    // All objects down at line 200, away from the captured lines
    task automatic park_objects();
        int i;
        for (i = 0; i < `VID_OBJS; i++) write_obj(i, 8'd0, 8'd200, 8'd0, 8'd0);
    endtask

    // Test pattern, diagonal stripes of transparent nibbles
    function automatic vid_pkg::nib_t pat_nib(input logic [3:0] code, input logic [2:0] row,
                                              input logic [2:0] col);
        int s;
        s = int'(code) + int'(row) + int'(col);
        if (((int'(row) + int'(col)) % 4) == 0) return 4'd0;
        return 4'(s % 15 + 1);
    endfunction

    // Reference pixel for column c of line v
    function automatic vid_pkg::color_t expected_pxl(input int c, input int v);
        logic [8:0]    vv;
        logic [8:0]    x;
        logic [10:0]   a;
        logic [8:0]    dx;
        logic [8:0]    dy;
        vid_pkg::nib_t tp;
        vid_pkg::nib_t op;
        logic          behind;
        logic          found;
        int            i;
        if (v >= `VID_VVIS || c >= `VID_HVIS) return '0;
        vv = 9'(v);
        x  = 9'(c + 2 * int'(scroll_sh >> 1) + 8);
        a  = {vv[7:3], x[8:3]};
        // Uniform ROM word, so every nibble is F or 0
        tp = attr_sh[a][3:0] ^ (code_sh[a][0] ? 4'hF : 4'h0);
        op = '0;
        behind = 1'b0;
        found  = 1'b0;
        for (i = 0; i < `VID_OBJS; i++) begin
            dx = 9'(c) - {1'b0, obj_sh[4*i]};
            dy = vv - {1'b0, obj_sh[4*i + 1]};
            if (!found && dx < 9'd8 && dy < 9'd8) begin
                found  = 1'b1;
                op     = pat_nib(obj_sh[4*i + 2][3:0], dy[2:0], dx[2:0]);
                behind = obj_sh[4*i + 3][7];
            end
        end
        if (op != 4'd0 && (!behind || tp == 4'd0)) return {1'b1, op};
        return {1'b0, tp};
    endfunction

    // Column c shows up one mixer delay later, while hdump is c+1
    task automatic capture_line(input int v);
        int c;
        wait_vblank();
        wait_beam(`VID_MIX_DLY, v);
        for (c = 0; c < `VID_HVIS; c++) begin
            cap[c] = pxl;
            wait_pixel();
        end
    endtask

    task automatic compare_line(input int v, input string tag);
        int c;
        vid_pkg::color_t exp;
        for (c = 0; c < `VID_HVIS; c++) begin
            exp = expected_pxl(c, v);
            checks++;
            if (cap[c] !== exp) begin
                errors++;
                $display("Fail pxl (%s, column %0d): got %h expected %h", tag, c, cap[c], exp);
            end
        end
    endtask

    task automatic test_reset();
        int n;
        int c;
        checks += 6;
        if (pxl !== '0) report_value("pxl", 32'(pxl), 0);
        if (LHBL !== 1'b0) report_value("LHBL", 32'(LHBL), 0);
        if (LVBL !== 1'b0) report_value("LVBL", 32'(LVBL), 0);
        if (hdump !== '0) report_value("hdump", 32'(hdump), 0);
        if (vdump !== '0) report_value("vdump", 32'(vdump), 0);
        if (rom_addr !== '0) report_value("rom_addr", 32'(rom_addr), 0);
        // One full line from its first pixel
        wait_beam(0, 1);
        n = 0;
        for (c = 0; c < `VID_HTOTAL; c++) begin
            if (LHBL) n++;
            wait_pixel();
        end
        checks++;
        if (n != `VID_HVIS) report_value("LHBL high count", 32'(n), `VID_HVIS);
    endtask

    task automatic test_memories();
        logic [11:0]    addrs [16];
        vid_pkg::byte_t got;
        vid_pkg::byte_t exp;
        int             i;
        for (i = 0; i < 16; i++) begin
            addrs[i] = 12'($urandom);
            cpu_write(1'b0, addrs[i], 8'($urandom));
        end
        for (i = 0; i < 16; i++) begin
            cpu_read(1'b0, addrs[i], got);
            exp = addrs[i][11] ? attr_sh[addrs[i][10:0]] : code_sh[addrs[i][10:0]];
            checks++;
            if (got !== exp) report_value("vram_dout", 32'(got), 32'(exp));
        end
        // Object table, written in full then read at random
        for (i = 0; i < 32; i++) cpu_write(1'b1, 12'(i), 8'($urandom));
        for (i = 0; i < 16; i++) begin
            addrs[i] = 12'($urandom % 32);
            cpu_read(1'b1, addrs[i], got);
            checks++;
            if (got !== obj_sh[addrs[i][4:0]]) report_value("obj_dout", 32'(got),
                                                            32'(obj_sh[addrs[i][4:0]]));
        end
    endtask

    task automatic test_tiles();
        int            i;
        logic [5:0]    t;
        vid_pkg::nib_t pal;
        for (i = 0; i < 256; i++) prog_load(1'b0, 10'(i), 4'(i >> 4) ^ 4'(i));
        for (i = 0; i < 1024; i++) prog_load(1'b1, 10'(i), pat_nib(4'(i >> 6), 3'(i >> 3), 3'(i)));
        park_objects();
        // Codes alternate odd and even, every third tile comes out as pixel 0
        for (i = 0; i < 64; i++) begin
            t   = 6'(i);
            pal = (i % 3 == 0) ? {4{t[0]}} : t[3:0];
            cpu_write(1'b0, {1'b0, 5'(CAP_LINE / 8), t}, 8'h20 + 8'(i));
            cpu_write(1'b0, {1'b1, 5'(CAP_LINE / 8), t}, {t[1:0], 1'b0, t[2], pal});
        end
        set_scroll(8'd0);
        capture_line(CAP_LINE);
        compare_line(CAP_LINE, "no scroll");
        for (i = 0; i < `VID_HVIS; i++) base[i] = cap[i];
    endtask

    task automatic test_scroll();
        int c;
        set_scroll(8'd16);
        capture_line(CAP_LINE);
        compare_line(CAP_LINE, "scroll 16");
        // Whole line moved left by 16 columns
        for (c = 0; c < `VID_HVIS - 16; c++) begin
            checks++;
            if (cap[c] !== base[c + 16]) report_value("pxl shifted", 32'(cap[c]),
                                                      32'(base[c + 16]));
        end
        set_scroll(8'd37);
        capture_line(CAP_LINE);
        compare_line(CAP_LINE, "scroll 37");
    endtask

    task automatic test_objects();
        set_scroll(8'd0);
        // Overlap at columns 104 to 107 of line 40
        write_obj(0, 8'd100, 8'd36, 8'd1, 8'h00);
        write_obj(1, 8'd104, 8'd38, 8'd2, 8'h00);
        capture_line(CAP_LINE);
        compare_line(CAP_LINE, "objects");
        checks += 2;
        if (cap[105] !== {1'b1, pat_nib(4'd1, 3'd4, 3'd5)})
            report_value("pxl overlap", 32'(cap[105]), 32'({1'b1, pat_nib(4'd1, 3'd4, 3'd5)}));
        // Object 0 transparent here, tile shows through
        if (cap[104][4] !== 1'b0) report_value("pxl layer bit", 32'(cap[104][4]), 0);
    endtask

    task automatic test_behind();
        park_objects();
        // Left half over an empty tile, right half over tile pixel 6
        write_obj(2, 8'd164, 8'd40, 8'd3, 8'h80);
        capture_line(CAP_LINE);
        compare_line(CAP_LINE, "behind");
        checks += 2;
        if (cap[165][4] !== 1'b1) report_value("pxl layer bit", 32'(cap[165][4]), 1);
        if (cap[169][4] !== 1'b0) report_value("pxl layer bit", 32'(cap[169][4]), 0);
        capture_line(230);
        compare_line(230, "vblank");
    endtask

    initial begin
        checks    = 0;
        errors    = 0;
        scroll_sh = '0;
        rst       = 1'b1;
        cpu_addr  = '0;
        cpu_dout  = '0;
        cpu_rnw   = 1'b1;
        vram_cs   = 1'b0;
        obj_cs    = 1'b0;
        scr_din   = '0;
        scr_we    = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        prog_we   = 1'b0;
        prog_sel  = 1'b0;
        void'($urandom(32'h4221_b4cf));
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        test_reset();
        test_memories();
        test_tiles();
        test_scroll();
        test_objects();
        test_behind();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+design
design/vid_pkg.sv
design/video_timing.sv
design/tile_scroll.sv
design/sprite_layer.sv
design/layer_mixer.sv
design/video_top.sv
tb/video_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Verilator build and run of video_tb, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --timescale 1ns/1ps --top-module video_tb \
    -f src.f -o video_tb_sim > build.log 2>&1 \
    && ./obj_dir/video_tb_sim > sim.log 2>&1 \
    || { echo "Build or simulation run error, see build.log and sim.log"; exit 1; }
grep -qxF -- ">>> PASS" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
